// File: verilog/math_pkg.sv
`default_nettype none

package math_pkg;

    // --------------------------------------------------
    // Q16.16 fixed point
    // --------------------------------------------------

    localparam int unsigned Q_FRAC_BITS = 16; // fraction bits below the binary point.
    localparam int unsigned Q_WIDTH     = 32; // total word width, sign included.

    // two's complement, value = raw / 2**Q_FRAC_BITS.
    typedef logic signed [Q_WIDTH-1:0] q16_16_t;

endpackage : math_pkg

`default_nettype wire

// File: verilog/vertex_pkg.sv
`default_nettype none

package vertex_pkg;

    import math_pkg::*;

    // --------------------------------------------------
    // geometry payloads
    // --------------------------------------------------

    // one camera-space or projected vertex, x in the top word.
    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vertex_t;

    // three vertices, v0 in the top words.
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

endpackage : vertex_pkg

`default_nettype wire

// File: verilog/fixed_divider.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_divider
    import math_pkg::*;
#(
    parameter int unsigned STEPS_PER_CYCLE = 1
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  logic [Q_WIDTH+Q_FRAC_BITS-1:0] dividend,
    input  logic [Q_WIDTH-1:0]             divisor,
    output logic [Q_WIDTH-1:0]             quotient,
    output logic                           done
);

    localparam int unsigned STEPS = Q_WIDTH / STEPS_PER_CYCLE;
    localparam int unsigned CNT_W = $clog2(STEPS + 1);

    if (STEPS_PER_CYCLE != 1 && STEPS_PER_CYCLE != 2 && STEPS_PER_CYCLE != 4) begin : g_bad_steps
        $error("fixed_divider: STEPS_PER_CYCLE must be 1, 2 or 4.");
    end

    logic [Q_WIDTH-1:0] rem_q;
    logic [Q_WIDTH-1:0] quo_q;    // low dividend bits shift out as quotient bits shift in.
    logic [Q_WIDTH-1:0] den_q;
    logic [Q_WIDTH-1:0] rem_next;
    logic [Q_WIDTH-1:0] quo_next;
    logic [Q_WIDTH:0]   trial;    // one bit wider than the remainder.
    logic [CNT_W-1:0]   count_q;
    logic               running_q;
    logic               done_q;

    // --------------------------------------------------
    // restoring steps, STEPS_PER_CYCLE per clock
    // --------------------------------------------------

    always_comb begin
        rem_next = rem_q;
        quo_next = quo_q;
        trial    = '0;
        for (int i = 0; i < STEPS_PER_CYCLE; i++) begin
            trial    = {rem_next, quo_next[Q_WIDTH-1]};
            quo_next = {quo_next[Q_WIDTH-2:0], 1'b0};
            if (trial >= {1'b0, den_q}) begin
                trial       = trial - {1'b0, den_q};
                quo_next[0] = 1'b1;
            end
            rem_next = trial[Q_WIDTH-1:0];
        end
    end

    // the high dividend word seeds the remainder, so the high word must be below the divisor
    // for the low quotient bits to be exact.
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= Q_WIDTH'(dividend[Q_WIDTH+Q_FRAC_BITS-1:Q_WIDTH]);
            quo_q <= dividend[Q_WIDTH-1:0];
            den_q <= divisor;
        end else if (running_q && count_q != '0) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running_q <= 1'b0;
            count_q   <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                running_q <= 1'b1;
                count_q   <= CNT_W'(STEPS);
            end else if (running_q) begin
                if (count_q != '0) begin
                    count_q <= count_q - 1'b1;
                end else begin
                    running_q <= 1'b0; // one cycle after the last step.
                    done_q    <= 1'b1;
                end
            end
        end
    end

    assign quotient = quo_q; // holds until the next start.
    assign done     = done_q;

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    a_divisor_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> divisor != '0);

    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !running_q);

endmodule : fixed_divider

`default_nettype wire

// File: verilog/vertex_projector.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_projector
    import math_pkg::*;
    import vertex_pkg::*;
#(
    parameter int unsigned STEPS_PER_CYCLE = 1
) (
    input  logic    clk,
    input  logic    arst_n,
    input  vertex_t vertex,
    input  logic    in_valid,
    output logic    in_ready,
    input  q16_16_t focal_length,
    output vertex_t out_vertex,
    output logic    out_valid,
    input  logic    out_ready,
    output logic    busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIVIDE,
        ST_HOLD
    } state_t;

    state_t                 state_q;
    logic                   start_q;
    logic                   accept;
    logic [2*Q_WIDTH-1:0]   x_prod;
    logic [2*Q_WIDTH-1:0]   y_prod;
    logic [Q_WIDTH-1:0]     prod_x_q;
    logic [Q_WIDTH-1:0]     prod_y_q;
    logic [Q_WIDTH-1:0]     z_mag_q;
    logic                   neg_x_q;
    logic                   neg_y_q;
    q16_16_t                z_q;
    logic [Q_WIDTH-1:0]     x_quo;
    logic [Q_WIDTH-1:0]     y_quo;
    logic                   x_done;
    logic                   y_done;
    logic                   div_done;

    function automatic logic [Q_WIDTH-1:0] magnitude(input q16_16_t v);
        return v[Q_WIDTH-1] ? Q_WIDTH'(-v) : Q_WIDTH'(v);
    endfunction

    assign accept = in_valid && in_ready;
    assign x_prod = magnitude(vertex.x) * magnitude(focal_length);
    assign y_prod = magnitude(vertex.y) * magnitude(focal_length);

    // --------------------------------------------------
    // multiply stage
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            prod_x_q <= x_prod[Q_WIDTH+Q_FRAC_BITS-1:Q_FRAC_BITS]; // wraps past 32 bits.
            prod_y_q <= y_prod[Q_WIDTH+Q_FRAC_BITS-1:Q_FRAC_BITS];
            z_mag_q  <= magnitude(vertex.z);
            neg_x_q  <= vertex.x[Q_WIDTH-1] ^ focal_length[Q_WIDTH-1] ^ vertex.z[Q_WIDTH-1];
            neg_y_q  <= vertex.y[Q_WIDTH-1] ^ focal_length[Q_WIDTH-1] ^ vertex.z[Q_WIDTH-1];
            z_q      <= vertex.z;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= accept; // dividers see the registered products next cycle.
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_DIVIDE;
                    end
                end
                ST_DIVIDE: begin
                    if (div_done) begin
                        state_q <= out_ready ? ST_IDLE : ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (out_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    fixed_divider #(
        .STEPS_PER_CYCLE(STEPS_PER_CYCLE)
    ) div_x (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start_q),
        .dividend ({prod_x_q, {Q_FRAC_BITS{1'b0}}}),
        .divisor  (z_mag_q),
        .quotient (x_quo),
        .done     (x_done)
    );

    fixed_divider #(
        .STEPS_PER_CYCLE(STEPS_PER_CYCLE)
    ) div_y (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start_q),
        .dividend ({prod_y_q, {Q_FRAC_BITS{1'b0}}}),
        .divisor  (z_mag_q),
        .quotient (y_quo),
        .done     (y_done)
    );

    // --------------------------------------------------
    // output side
    // --------------------------------------------------

    assign div_done     = x_done && y_done;
    assign out_vertex.x = neg_x_q ? q16_16_t'(-x_quo) : q16_16_t'(x_quo); // quotients hold.
    assign out_vertex.y = neg_y_q ? q16_16_t'(-y_quo) : q16_16_t'(y_quo);
    assign out_vertex.z = z_q;
    assign out_valid    = (state_q == ST_HOLD) || (state_q == ST_DIVIDE && div_done);
    assign in_ready     = (state_q == ST_IDLE);
    assign busy         = (state_q != ST_IDLE);

    a_z_positive: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> vertex.z > 0);

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_vertex));

endmodule : vertex_projector

`default_nettype wire

// File: verilog/triangle_projector.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_projector
    import math_pkg::*;
    import vertex_pkg::*;
#(
    parameter int unsigned STEPS_PER_CYCLE = 1
) (
    input  logic      clk,
    input  logic      arst_n,
    input  triangle_t triangle,
    input  logic      in_valid,
    output logic      in_ready,
    input  q16_16_t   focal_length,
    output triangle_t out_triangle,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      busy
);

    logic [2:0] lane_ready;
    logic [2:0] lane_valid;
    logic [2:0] lane_busy;
    logic       all_valid;
    logic       lane_out_ready;

    // --------------------------------------------------
    // lanes
    // --------------------------------------------------

    vertex_projector #(
        .STEPS_PER_CYCLE(STEPS_PER_CYCLE)
    ) project_v0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .vertex       (triangle.v0),
        .in_valid     (in_valid),
        .in_ready     (lane_ready[0]),
        .focal_length (focal_length),
        .out_vertex   (out_triangle.v0),
        .out_valid    (lane_valid[0]),
        .out_ready    (lane_out_ready),
        .busy         (lane_busy[0])
    );

    vertex_projector #(
        .STEPS_PER_CYCLE(STEPS_PER_CYCLE)
    ) project_v1 (
        .clk          (clk),
        .arst_n       (arst_n),
        .vertex       (triangle.v1),
        .in_valid     (in_valid),
        .in_ready     (lane_ready[1]),
        .focal_length (focal_length),
        .out_vertex   (out_triangle.v1),
        .out_valid    (lane_valid[1]),
        .out_ready    (lane_out_ready),
        .busy         (lane_busy[1])
    );

    vertex_projector #(
        .STEPS_PER_CYCLE(STEPS_PER_CYCLE)
    ) project_v2 (
        .clk          (clk),
        .arst_n       (arst_n),
        .vertex       (triangle.v2),
        .in_valid     (in_valid),
        .in_ready     (lane_ready[2]),
        .focal_length (focal_length),
        .out_vertex   (out_triangle.v2),
        .out_valid    (lane_valid[2]),
        .out_ready    (lane_out_ready),
        .busy         (lane_busy[2])
    );

    assign all_valid      = &lane_valid;
    assign lane_out_ready = out_ready && all_valid; // lanes retire together.
    assign out_valid      = all_valid;
    assign in_ready       = &lane_ready;
    assign busy           = |lane_busy;

    // lanes that drift apart would accept partial triangles.
    a_lanes_locked: assert property (@(posedge clk) disable iff (!arst_n)
        (&lane_ready) || !(|lane_ready));

endmodule : triangle_projector

`default_nettype wire

// File: verilog/projection_top.sv
`timescale 1ns/1ps
`default_nettype none

module projection_top
    import math_pkg::*;
    import vertex_pkg::*;
#(
    parameter int unsigned STEPS_PER_CYCLE = 2 // quotient bits per divider cycle.
) (
    input  logic      clk,
    input  logic      arst_n,
    input  triangle_t triangle,
    input  logic      in_valid,
    output logic      in_ready,
    input  q16_16_t   focal_length,
    output triangle_t out_triangle,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      busy
);

    // --------------------------------------------------
    // projection core
    // --------------------------------------------------

    triangle_projector #(
        .STEPS_PER_CYCLE(STEPS_PER_CYCLE)
    ) u_triangle_projector (
        .clk          (clk),
        .arst_n       (arst_n),
        .triangle     (triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .focal_length (focal_length), // held stable while busy.
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy)
    );

endmodule : projection_top

`default_nettype wire

// File: dv/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// --------------------------------------------------
// projection reference
// --------------------------------------------------

function automatic logic [31:0] magnitude_of(input q16_16_t v);
    return (v < 0) ? ~v + 32'd1 : v;
endfunction

// works on magnitudes and applies the sign last, so every step truncates toward zero.
function automatic q16_16_t project_coord(input q16_16_t c, input q16_16_t f, input q16_16_t z);
    logic        negative;
    logic [63:0] scaled;
    logic [63:0] ratio;
    logic [31:0] result;
    negative = (c < 0) ^ (f < 0) ^ (z < 0);
    scaled   = {32'd0, magnitude_of(c)} * {32'd0, magnitude_of(f)};
    scaled   = {32'd0, scaled[Q_FRAC_BITS+31:Q_FRAC_BITS]}; // kept to 32 bits.
    ratio    = (scaled << Q_FRAC_BITS) / {32'd0, magnitude_of(z)};
    result   = ratio[31:0];                                 // overflow wraps.
    return negative ? -result : result;
endfunction

function automatic vertex_t project_vertex(input vertex_t v, input q16_16_t f);
    vertex_t p;
    p.x = project_coord(v.x, f, v.z);
    p.y = project_coord(v.y, f, v.z);
    p.z = v.z;
    return p;
endfunction

function automatic triangle_t project_triangle(input triangle_t t, input q16_16_t f);
    triangle_t p;
    p.v0 = project_vertex(t.v0, f);
    p.v1 = project_vertex(t.v1, f);
    p.v2 = project_vertex(t.v2, f);
    return p;
endfunction

// galois form with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`endif

// File: dv/tb_projection_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_projection_top
    import math_pkg::*;
    import vertex_pkg::*;
();

    `include "tb_ref_model.svh"

    localparam int          CLK_PERIOD    = 10;
    localparam int          LATENCY       = 32 / 2 + 2; // multiply cycle plus the divider.
    localparam int          NUM_TRIANGLES = 200;
    localparam int          FIXED_COUNT   = 100;        // first triangles see out_ready high.
    localparam int          MAX_STALL     = 8;
    localparam int          WATCHDOG_NS   = NUM_TRIANGLES * (LATENCY + MAX_STALL) * CLK_PERIOD * 2;
    localparam logic [31:0] SEED          = 32'h35ad5181;

    logic        clk;
    logic        arst_n;
    triangle_t   triangle;
    logic        in_valid;
    logic        in_ready;
    q16_16_t     focal_length;
    triangle_t   out_triangle;
    logic        out_valid;
    logic        out_ready;
    logic        busy;

    logic [31:0] lfsr_state;
    logic        stall_mode;
    int          low_run;
    int          received_count;
    triangle_t   exp_q[$];
    triangle_t   exp_front;
    triangle_t   held_triangle;
    logic        pending;
    logic        in_xfer;
    logic        out_xfer;

    projection_top dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .triangle     (triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .focal_length (focal_length),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // --------------------------------------------------
    // random stimulus
    // --------------------------------------------------

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic q16_16_t random_coord();
        return q16_16_t'(draw_bits(23)) - 32'sd4194304; // -64.0 up to just under 64.0.
    endfunction

    function automatic q16_16_t random_z();
        return q16_16_t'(32'd65536 + (draw_bits(22) % 32'd4128769)); // 1.0 to 64.0.
    endfunction

    function automatic q16_16_t random_focal();
        return q16_16_t'(32'd32768 + (draw_bits(18) % 32'd229377)); // 0.5 to 4.0.
    endfunction

    function automatic vertex_t random_vertex();
        vertex_t v;
        v.x = random_coord();
        v.y = random_coord();
        v.z = random_z();
        return v;
    endfunction

    function automatic triangle_t random_triangle();
        triangle_t t;
        t.v0 = random_vertex();
        t.v1 = random_vertex();
        t.v2 = random_vertex();
        return t;
    endfunction

    // low runs are capped so the watchdog bound holds.
    function automatic logic next_ready();
        logic [31:0] bits;
        if (!stall_mode) begin
            return 1'b1;
        end
        if (low_run >= MAX_STALL) begin
            low_run = 0;
            return 1'b1;
        end
        bits = draw_bits(1);
        if (bits[0]) begin
            low_run = 0;
            return 1'b1;
        end
        low_run++;
        return 1'b0;
    endfunction

    task automatic run_triangle();
        logic [31:0] gap;
        logic        handed_over;
        gap = draw_bits(2);
        repeat (gap) @(negedge clk);
        focal_length = random_focal();
        triangle     = random_triangle();
        in_valid     = 1'b1;
        while (!in_ready) @(negedge clk);
        @(negedge clk);
        in_valid    = 1'b0;
        handed_over = 1'b0;
        while (!handed_over) begin
            out_ready   = next_ready();
            handed_over = out_valid && out_ready; // transfer on the coming edge.
            @(negedge clk);
        end
    endtask

    // --------------------------------------------------
    // scoreboard
    // --------------------------------------------------

    assign in_xfer  = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            received_count = 0;
            pending       <= 1'b0;
            exp_front     <= '0;
        end else begin
            if (in_xfer) begin
                exp_q.push_back(project_triangle(triangle, focal_length));
            end
            if (out_xfer && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                received_count++;
            end
            pending   <= (exp_q.size() != 0);
            exp_front <= (exp_q.size() != 0) ? exp_q[0] : '0;
        end
    end

    always @(posedge clk) begin
        held_triangle <= out_triangle;
    end

    a_result: assert property (@(posedge clk) disable iff (!arst_n)
        out_xfer && pending |-> out_triangle == exp_front)
        else begin
            $display("FAIL %0t out_triangle expected %h got %h", $time, exp_front, out_triangle);
            abort_run();
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
        out_xfer |-> pending)
        else begin
            $display("an output triangle was handed over with no input waiting for it");
            abort_run();
        end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        !stall_mode |-> out_valid == $past(in_xfer, LATENCY + 1))
        else begin
            $display("FAIL %0t out_valid expected %b got %b", $time,
                     $past(in_xfer, LATENCY + 1), out_valid);
            abort_run();
        end

    a_hold_valid: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid)
        else begin
            $display("out_valid dropped before the output triangle was taken");
            abort_run();
        end

    a_hold_data: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_triangle == held_triangle)
        else begin
            $display("FAIL %0t out_triangle expected %h got %h", $time, held_triangle,
                     out_triangle);
            abort_run();
        end

    a_busy_blocks: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !in_ready)
        else begin
            $display("FAIL %0t in_ready expected 0 got %b", $time, in_ready);
            abort_run();
        end

    a_busy: assert property (@(posedge clk) disable iff (!arst_n)
        busy == pending)
        else begin
            $display("FAIL %0t busy expected %b got %b", $time, pending, busy);
            abort_run();
        end

    a_idle_ready: assert property (@(posedge clk) disable iff (!arst_n)
        !pending |-> in_ready)
        else begin
            $display("FAIL %0t in_ready expected 1 got %b", $time, in_ready);
            abort_run();
        end

    a_idle_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !pending |-> !out_valid)
        else begin
            $display("FAIL %0t out_valid expected 0 got %b", $time, out_valid);
            abort_run();
        end

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------

    initial begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        triangle     = '0;
        focal_length = 32'sh0001_0000;
        out_ready    = 1'b1;
        stall_mode   = 1'b0;
        low_run      = 0;
        lfsr_state   = SEED;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int n = 0; n < NUM_TRIANGLES; n++) begin
            stall_mode = (n >= FIXED_COUNT); // switches only while the DUT is idle.
            run_triangle();
        end
        out_ready = 1'b1;
        repeat (2) @(negedge clk);
        if (exp_q.size() == 0 && received_count == NUM_TRIANGLES) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d of %0d triangles came back and %0d are still expected",
                     received_count, NUM_TRIANGLES, exp_q.size());
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all triangles were checked", WATCHDOG_NS);
        abort_run();
    end

endmodule : tb_projection_top

`default_nettype wire

// File: filelist.f
+incdir+dv
verilog/math_pkg.sv
verilog/vertex_pkg.sv
verilog/fixed_divider.sv
verilog/vertex_projector.sv
verilog/triangle_projector.sv
verilog/projection_top.sv
dv/tb_projection_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the projection testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

top=tb_projection_top
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module "$top" -f filelist.f -o "$top"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "error: verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "error: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail, pass line not found in $log"
exit 1
